// File: hw/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Architectural integer registers, x0 included.
`define NUM_REGS 32

// Data memory size in 32-bit words. Addresses wrap at this size.
`define DMEM_WORDS 64

`define XLEN 32

// Register index width for NUM_REGS entries.
`define REG_AW 5

`endif

// File: hw/pipePkg.sv
`include "pipe_params.svh"

package pipePkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_s;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_s;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_s;

    // One instruction word, seen through each RISC-V format.
    typedef union packed {
        rType_s r;
        iType_s i;
        sType_s s;
        bType_s b;
        jType_s j;
    } instrWord_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB
    } aluOp_e;

    typedef struct packed {
        logic   regWrite;
        logic   resultSrc; // 1 selects memory data.
        logic   memWrite;
        logic   memType;   // 1 is a byte access.
        aluOp_e aluCtrl;
        logic   aluSrc;    // 1 selects the immediate.
        logic   isBranch;
        logic   branchNe;
        logic   isJump;
    } ctrl_s;

    typedef struct packed {
        ctrl_s              ctrl;
        logic [`XLEN-1:0]   rd1;
        logic [`XLEN-1:0]   rd2;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   extImm;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   linkAddr;
    } decExe_s;

    typedef struct packed {
        logic               regWrite;
        logic               resultSrc;
        logic               memType;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   aluResult;
        logic [1:0]         byteSel;
    } exeWb_s;

    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } wbPort_s;

endpackage

// File: hw/instrDecoder.sv
`include "pipe_params.svh"

module instrDecoder import pipePkg::*; (
    input  instrWord_u         instr,
    output ctrl_s              ctrl,
    output logic [`XLEN-1:0]   extImm,
    output logic [`REG_AW-1:0] rs1,
    output logic [`REG_AW-1:0] rs2,
    output logic [`REG_AW-1:0] rd
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immJ;

    function automatic aluOp_e aluOf(input logic [2:0] funct3, input logic isSub);
        aluOp_e op;
        case (funct3)
            3'b000:  op = isSub ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b101:  op = ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    assign immI = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign immS = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
    assign immB = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                   instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign immJ = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                   instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        ctrl   = '0;
        extImm = '0;
        case (instr.r.opcode)
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = aluOf(instr.r.funct3, instr.r.funct7[5]);
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluCtrl  = aluOf(instr.i.funct3, 1'b0);
                extImm        = immI;
            end
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.memType   = (instr.i.funct3 == 3'b100); // LBU, else LW.
                extImm         = immI;
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memType  = (instr.s.funct3 == 3'b000); // SB, else SW.
                extImm        = immS;
            end
            OP_BRANCH: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = instr.b.funct3[0];
                extImm        = immB;
            end
            OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.isJump   = 1'b1;
                extImm        = immJ;
            end
            default: ctrl = '0;
        endcase

        // SLTU and the halfword forms are not implemented and run as no-ops.
        if (instr.r.opcode == OP_REG || instr.r.opcode == OP_IMM) begin
            if (instr.r.funct3 == 3'b011) ctrl = '0;
        end
        if (instr.r.opcode == OP_LOAD) begin
            if (instr.i.funct3 != 3'b010 && instr.i.funct3 != 3'b100) ctrl = '0;
        end
        if (instr.r.opcode == OP_STORE) begin
            if (instr.s.funct3 != 3'b000 && instr.s.funct3 != 3'b010) ctrl = '0;
        end
        if (instr.r.opcode == OP_BRANCH && instr.b.funct3[2:1] != 2'b00) ctrl = '0;
    end

endmodule

// File: hw/regFile.sv
`include "pipe_params.svh"

module regFile import pipePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    input  logic               wbValid,
    input  wbPort_s            wb,
    output logic [`XLEN-1:0]   rd1,
    output logic [`XLEN-1:0]   rd2
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // Writeback never targets x0, which keeps its reset value.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // A write landing this cycle is visible to the reader right away.
    always_comb begin
        rd1 = (wbValid && wb.rd == rs1) ? wb.data : regs[rs1];
        rd2 = (wbValid && wb.rd == rs2) ? wb.data : regs[rs2];
        if (rs1 == '0) rd1 = '0;
        if (rs2 == '0) rd2 = '0;
    end

    xZeroHeld: assert property (@(posedge clk) disable iff (rst)
        wbValid |=> regs[0] == '0)
        else $error("x0 was overwritten by writeback");

endmodule

// File: hw/regD.sv
module regD import pipePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    load,
    input  logic    flush,
    input  decExe_s dIn,
    output decExe_s dOut
);

    logic bubble;

    assign bubble = rst || flush || !load;

    // Operands and immediates only move on a real load.
    always_ff @(posedge clk) begin
        if (load) begin
            dOut <= dIn;
        end
        if (bubble) begin
            dOut.ctrl <= '0; // Kills the slot without touching data.
        end
    end

    // A flush always comes from the branch or jump held in this slot.
    flushFromBranch: assert property (@(posedge clk) disable iff (rst)
        flush |-> dOut.ctrl.isBranch || dOut.ctrl.isJump)
        else $error("flush raised without a branch or jump in execute");

endmodule

// File: hw/executeUnit.sv
`include "pipe_params.svh"

module executeUnit import pipePkg::*; (
    input  decExe_s          dIn,
    input  logic             wbValid,
    input  wbPort_s          wb,
    output exeWb_s           exeOut,
    output logic [`XLEN-1:0] storeData,
    output logic [`XLEN-1:0] memAddr,
    output logic             flush,
    output logic [`XLEN-1:0] redirectPc,
    output logic             memWrite
);

    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluRes;
    logic             taken;

    // The writeback stage is the only forward source. Distance two is
    // covered by the register file bypass.
    assign srcA = (wbValid && wb.rd == dIn.rs1) ? wb.data : dIn.rd1;
    assign srcB = (wbValid && wb.rd == dIn.rs2) ? wb.data : dIn.rd2;
    assign aluB = dIn.ctrl.aluSrc ? dIn.extImm : srcB;

    always_comb begin
        case (dIn.ctrl.aluCtrl)
            ALU_ADD:   aluRes = srcA + aluB;
            ALU_SUB:   aluRes = srcA - aluB;
            ALU_AND:   aluRes = srcA & aluB;
            ALU_OR:    aluRes = srcA | aluB;
            ALU_XOR:   aluRes = srcA ^ aluB;
            ALU_SLT:   aluRes = {31'b0, $signed(srcA) < $signed(aluB)};
            ALU_SLL:   aluRes = srcA << aluB[4:0];
            ALU_SRL:   aluRes = srcA >> aluB[4:0];
            ALU_PASSB: aluRes = aluB;
            default:   aluRes = '0;
        endcase
    end

    assign taken      = dIn.ctrl.isBranch && ((srcA == srcB) != dIn.ctrl.branchNe);
    assign flush      = taken || dIn.ctrl.isJump;
    assign redirectPc = dIn.pc + dIn.extImm;

    always_comb begin
        exeOut.regWrite  = dIn.ctrl.regWrite;
        exeOut.resultSrc = dIn.ctrl.resultSrc;
        exeOut.memType   = dIn.ctrl.memType;
        exeOut.rd        = dIn.rd;
        exeOut.aluResult = dIn.ctrl.isJump ? dIn.linkAddr : aluRes; // JAL links pc+4.
        exeOut.byteSel   = aluRes[1:0];
    end

    assign memAddr   = aluRes;
    assign storeData = srcB;
    assign memWrite  = dIn.ctrl.memWrite;

endmodule

// File: hw/memWriteback.sv
`include "pipe_params.svh"

module memWriteback import pipePkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  exeWb_s           exeIn,
    input  logic             memWrite,
    input  logic             memType,
    input  logic [`XLEN-1:0] memAddr,
    input  logic [`XLEN-1:0] storeData,
    output logic             wbValid,
    output wbPort_s          wb
);

    localparam int AddrW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [`XLEN-1:0] memRdata;
    logic [AddrW-1:0] wordIdx;
    logic [3:0]       laneEn;
    logic [7:0]       loadByte;
    exeWb_s           wbReg;

    assign wordIdx = memAddr[AddrW+1:2];
    assign laneEn  = memType ? (4'b0001 << memAddr[1:0]) : 4'b1111;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (laneEn[b]) begin
                    mem[wordIdx][8*b +: 8] <= memType ? storeData[7:0] : storeData[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        memRdata <= mem[wordIdx];
    end

    always_ff @(posedge clk) begin
        wbReg <= exeIn;
        if (rst) begin
            wbReg.regWrite  <= 1'b0;
            wbReg.resultSrc <= 1'b0;
        end
    end

    assign loadByte = memRdata[8*wbReg.byteSel +: 8];

    always_comb begin
        wb.rd = wbReg.rd;
        if (!wbReg.resultSrc) begin
            wb.data = wbReg.aluResult;
        end else if (wbReg.memType) begin
            wb.data = {24'b0, loadByte}; // LBU zero-extends.
        end else begin
            wb.data = memRdata;
        end
    end

    assign wbValid = wbReg.regWrite && wbReg.rd != '0;

    wordAligned: assert property (@(posedge clk) disable iff (rst)
        ((memWrite || exeIn.resultSrc) && !memType) |-> memAddr[1:0] == 2'b00)
        else $error("misaligned word access at %h", memAddr);

endmodule

// File: hw/pipeCore.sv
`include "pipe_params.svh"

module pipeCore import pipePkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  instrWord_u       instr,
    input  logic [`XLEN-1:0] pc,
    output logic             instrReady,
    output logic             wbValid,
    output wbPort_s          wb,
    output logic             redirectValid,
    output logic [`XLEN-1:0] redirectPc
);

    ctrl_s              decCtrl;
    logic [`XLEN-1:0]   decImm;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   rd1;
    logic [`XLEN-1:0]   rd2;
    logic               accept;
    logic               flush;
    decExe_s            decIn;
    decExe_s            decOut;
    exeWb_s             exeOut;
    logic [`XLEN-1:0]   storeData;
    logic [`XLEN-1:0]   memAddr;
    logic               memWrite;

    // Nothing stalls, so ready only waits out reset.
    always_ff @(posedge clk) begin
        if (rst) instrReady <= 1'b0;
        else instrReady <= 1'b1;
    end

    assign accept = instrValid && instrReady;

    instrDecoder u_dec (
        .instr  (instr),
        .ctrl   (decCtrl),
        .extImm (decImm),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd)
    );

    regFile u_rf (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .wbValid (wbValid),
        .wb      (wb),
        .rd1     (rd1),
        .rd2     (rd2)
    );

    always_comb begin
        decIn.ctrl     = decCtrl;
        decIn.rd1      = rd1;
        decIn.rd2      = rd2;
        decIn.rs1      = rs1;
        decIn.rs2      = rs2;
        decIn.rd       = rd;
        decIn.extImm   = decImm;
        decIn.pc       = pc;
        decIn.linkAddr = pc + 32'd4;
    end

    regD u_regD (
        .clk   (clk),
        .rst   (rst),
        .load  (accept),
        .flush (flush), // Annuls the instruction behind a taken branch.
        .dIn   (decIn),
        .dOut  (decOut)
    );

    executeUnit u_exe (
        .dIn        (decOut),
        .wbValid    (wbValid),
        .wb         (wb),
        .exeOut     (exeOut),
        .storeData  (storeData),
        .memAddr    (memAddr),
        .flush      (flush),
        .redirectPc (redirectPc),
        .memWrite   (memWrite)
    );

    assign redirectValid = flush;

    memWriteback u_mwb (
        .clk       (clk),
        .rst       (rst),
        .exeIn     (exeOut),
        .memWrite  (memWrite),
        .memType   (exeOut.memType),
        .memAddr   (memAddr),
        .storeData (storeData),
        .wbValid   (wbValid),
        .wb        (wb)
    );

endmodule

// File: testbench/pipeCoreTb.sv
module pipeCoreTb import pipePkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst;
    logic        instrValid;
    instrWord_u  instr;
    logic [31:0] pc;
    logic        instrReady;
    logic        wbValid;
    wbPort_s     wb;
    logic        redirectValid;
    logic [31:0] redirectPc;
    int          cyc;

    // Stimulus table.
    string       names[$];
    logic [31:0] words[$];
    logic [31:0] pcs[$];
    int          idles[$];

    // Expected results, filled by the model in program order.
    wbPort_s     expWb[$];
    string       expWbName[$];
    int          expWbCyc[$];
    logic [31:0] expRed[$];
    string       expRedName[$];
    int          expRedCyc[$];

    logic [31:0] regM [32];
    logic [31:0] memM [64];
    int          annulAt = -1;

    pipeCore dut_i (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr), .pc(pc),
        .instrReady(instrReady), .wbValid(wbValid), .wb(wb),
        .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkWb(input string name, input wbPort_s exp, input wbPort_s act);
        if (act !== exp) begin
            failNow($sformatf("mismatch %s expected x%0d=%h actual x%0d=%h",
                name, exp.rd, exp.data, act.rd, act.data));
        end
    endtask

    task automatic checkRedirect(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            failNow($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input int r2, input int r1,
                                         input logic [2:0] f3, input int rd);
        return {f7, 5'(r2), 5'(r1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input int imm, input int r1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] op);
        logic [11:0] im;
        im = 12'(imm);
        return {im, 5'(r1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] encS(input int imm, input int r2, input int r1,
                                         input logic [2:0] f3);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(r2), 5'(r1), f3, im[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input int imm, input int r2, input int r1,
                                         input logic [2:0] f3);
        logic [12:0] im;
        im = 13'(imm);
        return {im[12], im[10:5], 5'(r2), 5'(r1), f3, im[4:1], im[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input int imm, input int rd);
        logic [20:0] im;
        im = 21'(imm);
        return {im[20], im[10:1], im[11], im[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic addTest(input string name, input logic [31:0] w, input int idle);
        names.push_back(name);
        words.push_back(w);
        pcs.push_back(32'h100 + 32'(4 * pcs.size()));
        idles.push_back(idle);
    endtask

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd4: return a ^ b;
            3'd5: return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Predicts the architectural effect of one instruction accepted at edge acc.
    task automatic predict(input int t, input int acc);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] tgt;
        logic        wr;
        logic        redir;
        wbPort_s     e;
        w = words[t];
        a = regM[w[19:15]];
        b = regM[w[24:20]];
        wr = 1'b0;
        redir = 1'b0;
        res = '0;
        tgt = '0;
        if (acc == annulAt) return; // Squashed behind a taken branch.
        case (w[6:0])
            7'b0110011: begin
                res = aluRef(w[14:12], w[30], a, b);
                wr = 1'b1;
            end
            7'b0010011: begin
                res = aluRef(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
                wr = 1'b1;
            end
            7'b0000011: begin
                addr = a + {{20{w[31]}}, w[31:20]};
                res = memM[addr[7:2]];
                if (w[14:12] == 3'd4) res = {24'b0, res[8*addr[1:0] +: 8]};
                wr = 1'b1;
            end
            7'b0100011: begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                if (w[14:12] == 3'd0) memM[addr[7:2]][8*addr[1:0] +: 8] = b[7:0];
                else memM[addr[7:2]] = b;
            end
            7'b1100011: begin
                redir = (a == b) != w[12];
                tgt = pcs[t] + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b1101111: begin
                redir = 1'b1;
                tgt = pcs[t] + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                res = pcs[t] + 32'd4;
                wr = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            regM[w[11:7]] = res;
            e.rd = w[11:7];
            e.data = res;
            expWb.push_back(e);
            expWbName.push_back(names[t]);
            expWbCyc.push_back(acc + 1);
        end
        if (redir) begin
            expRed.push_back(tgt);
            expRedName.push_back(names[t]);
            expRedCyc.push_back(acc);
            annulAt = acc + 1;
        end
    endtask

    always @(negedge clk) begin
        if (rst && cyc > 0) begin
            if (instrReady !== 1'b0 || wbValid !== 1'b0 || redirectValid !== 1'b0) begin
                failNow("outputs were active during reset");
            end
        end
        if (instrValid && instrReady !== 1'b1) begin
            failNow("instrReady was low while an instruction was offered");
        end
        if (!rst && wbValid) begin
            if (expWb.size() == 0) failNow($sformatf("unexpected writeback to x%0d", wb.rd));
            checkWb(expWbName[0], expWb[0], wb);
            if (cyc != expWbCyc[0]) failNow($sformatf("%s wrote back in cycle %0d, not %0d",
                expWbName[0], cyc, expWbCyc[0]));
            void'(expWb.pop_front());
            void'(expWbName.pop_front());
            void'(expWbCyc.pop_front());
        end
        if (!rst && redirectValid) begin
            if (expRed.size() == 0) failNow($sformatf("unexpected redirect to %h", redirectPc));
            checkRedirect(expRedName[0], expRed[0], redirectPc);
            if (cyc != expRedCyc[0]) failNow($sformatf("%s redirected in cycle %0d, not %0d",
                expRedName[0], cyc, expRedCyc[0]));
            void'(expRed.pop_front());
            void'(expRedName.pop_front());
            void'(expRedCyc.pop_front());
        end
    end

    initial begin
        int idle;
        int waitCnt;
        clk = 1'b0;
        rst = 1'b1;
        cyc = 0;
        instrValid = 1'b0;
        instr = '0;
        pc = '0;
        void'($urandom(58481));
        for (int i = 0; i < 32; i++) regM[i] = '0;
        for (int i = 0; i < 64; i++) memM[i] = '0;

        addTest("addi x1", encI(5, 0, 3'd0, 1, 7'b0010011), 0);
        addTest("addi x2 neg", encI(-7, 0, 3'd0, 2, 7'b0010011), 0);
        addTest("add dist1/2", encR(7'h00, 2, 1, 3'd0, 3), 0);
        addTest("sub dist1", encR(7'h20, 1, 3, 3'd0, 4), 0);
        addTest("slt neg", encR(7'h00, 1, 2, 3'd2, 5), 0);
        addTest("slti", encI(-1, 1, 3'd2, 6, 7'b0010011), 1);
        addTest("sll", encR(7'h00, 1, 1, 3'd1, 7), 0);
        addTest("srli", encI(4, 2, 3'd5, 8, 7'b0010011), 0);
        addTest("xor", encR(7'h00, 2, 1, 3'd4, 9), 0);
        addTest("or", encR(7'h00, 2, 1, 3'd6, 10), 0);
        addTest("andi", encI(12'h0f3, 2, 3'd7, 11, 7'b0010011), 2);
        addTest("slli", encI(3, 2, 3'd1, 18, 7'b0010011), 0);
        addTest("addi x0", encI(3, 1, 3'd0, 0, 7'b0010011), 0);
        addTest("base addr", encI(12'h40, 0, 3'd0, 12, 7'b0010011), 0);
        addTest("sw", encS(4, 2, 12, 3'd2), 0);
        addTest("lw after sw", encI(4, 12, 3'd2, 13, 7'b0000011), 0);
        addTest("sb", encS(5, 1, 12, 3'd0), 0);
        addTest("lw after sb", encI(4, 12, 3'd2, 14, 7'b0000011), 0);
        addTest("lbu", encI(5, 12, 3'd4, 15, 7'b0000011), 0);
        addTest("lbu other", encI(7, 12, 3'd4, 16, 7'b0000011), 0);
        addTest("load use", encR(7'h00, 14, 15, 3'd0, 17), 1);
        addTest("beq taken", encB(16, 1, 1, 3'd0), 0);
        addTest("annul beq", encI(1, 0, 3'd0, 20, 7'b0010011), 1);
        addTest("bne not taken", encB(8, 1, 1, 3'd1), 0);
        addTest("after bne", encI(2, 0, 3'd0, 22, 7'b0010011), 0);
        addTest("bne taken", encB(-8, 2, 1, 3'd1), 0);
        addTest("annul bne", encI(3, 0, 3'd0, 24, 7'b0010011), 0);
        addTest("jal", encJ(32, 23), 0);
        addTest("annul jal", encI(4, 0, 3'd0, 25, 7'b0010011), 2);
        addTest("jal x0", encJ(-64, 0), 2);
        addTest("use link", encR(7'h00, 1, 23, 3'd0, 26), 0);

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        waitCnt = 0;
        while (!instrReady) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > 20) failNow("instrReady never rose after reset");
        end

        for (int t = 0; t < names.size(); t++) begin
            instrValid <= 1'b1;
            instr <= words[t];
            pc <= pcs[t];
            predict(t, cyc + 2);
            @(posedge clk);
            idle = idles[t];
            if (idle > 0) idle += $urandom_range(2, 0);
            for (int k = 0; k < idle; k++) begin
                instrValid <= 1'b0;
                @(posedge clk);
            end
        end
        instrValid <= 1'b0;

        waitCnt = 0;
        while (expWb.size() > 0 || expRed.size() > 0) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > 20) failNow("timed out waiting for outstanding results");
        end
        repeat (4) @(posedge clk); // Catches stray late outputs.

        $display("all tests passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/pipePkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/regD.sv
hw/executeUnit.sv
hw/memWriteback.sv
hw/pipeCore.sv
testbench/pipeCoreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module pipeCoreTb -o simv

# The simulator exits nonzero on a fatal check, so the log decides the result.
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"
